//--- rtl/fe_pkg.sv
/*
 * Shared definitions for the fetch front end:
 * address and instruction types, register index type,
 * jal/jalr opcodes and the link register numbers
 */
`default_nettype none

package fe_pkg;

  // ---------------------------------------------------------------------
  // Widths and types
  // ---------------------------------------------------------------------

  // Address width of the program counter
  localparam int unsigned XLEN = 32;

  // Program counter or return address
  typedef logic [XLEN-1:0] addr_t;

  // Raw 32-bit instruction word
  typedef logic [31:0] inst_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // ---------------------------------------------------------------------
  // Encodings
  // ---------------------------------------------------------------------

  // Major opcodes of the unconditional jumps
  localparam logic [6:0] OPC_JAL  = 7'b110_1111;
  localparam logic [6:0] OPC_JALR = 7'b110_0111;

  // Link registers by the standard calling convention
  // ra is the usual one, t0 the alternate
  localparam reg_idx_t LINK_X1 = 5'd1;
  localparam reg_idx_t LINK_X5 = 5'd5;

endpackage : fe_pkg

`default_nettype wire

//--- rtl/ras_ctrl_if.sv
/*
 * Control and data bundle between the call/return detector
 * and the return address stack
 */
`timescale 1ns/100ps
`default_nettype none

interface ras_ctrl_if;

  import fe_pkg::*;

  // Push strobe, a call was fetched
  logic  push;
  // Pop strobe, a return was fetched
  logic  pop;
  // Address to push, PC+4 of the call
  addr_t ret_addr;
  // Most recently pushed address
  addr_t top_addr;

  // Detector side
  modport det (output push, output pop, output ret_addr);

  // Stack side
  modport stk (input push, input pop, input ret_addr, output top_addr);

endinterface : ras_ctrl_if

`default_nettype wire

//--- rtl/updown_counter.sv
/*
 * Wrapping up/down counter with enable, synchronous clear
 * and a direction-dependent terminal count flag
 */
`timescale 1ns/100ps
`default_nettype none

module updown_counter #(
  parameter int unsigned W = 2
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         en_i,
  input  logic         clr_i,
  input  logic         up_dn_i,
  output logic [W-1:0] count_o,
  output logic         tc_o
);

  logic [W-1:0] count_q;

  // Clear wins over counting, wraps modulo 2^W
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (en_i) begin
      if (up_dn_i) begin
        count_q <= count_q + 1'b1;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign count_o = count_q;

  // All ones going up, zero going down
  assign tc_o = up_dn_i ? (&count_q) : ~(|count_q);

endmodule : updown_counter

`default_nettype wire

//--- rtl/ras.sv
/*
 * Return address stack
 * Circular buffer of RAS_DEPTH addresses, written on push and
 * read combinationally at the entry below the next free index
 */
`timescale 1ns/100ps
`default_nettype none

module ras #(
  parameter int unsigned RAS_DEPTH = 4
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  ras_ctrl_if.stk        ctrl
);

  import fe_pkg::*;

  // Index width, at least one bit
  localparam int unsigned IdxW = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

  // ---------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------

  // Stored return addresses
  addr_t ras_q [RAS_DEPTH];

  // Next free slot and current top of stack
  logic [IdxW-1:0] new_idx;
  logic [IdxW-1:0] last_idx;

  // Counter controls
  logic cnt_en;
  logic cnt_up;

  // Push overwrites the slot at the next free index
  // On overflow this is the oldest entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      foreach (ras_q[i]) begin
        ras_q[i] <= '0;
      end
    end else if (ctrl.push) begin
      ras_q[new_idx] <= ctrl.ret_addr;
    end
  end

  // ---------------------------------------------------------------------
  // Index counter
  // ---------------------------------------------------------------------

  // Moves only when push and pop differ
  assign cnt_en = ctrl.push ^ ctrl.pop;
  assign cnt_up = ctrl.push;

  updown_counter #(
    .W (IdxW)
  ) new_idx_cnt_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (cnt_en),
    .clr_i   (1'b0),
    .up_dn_i (cnt_up),
    .count_o (new_idx),
    .tc_o    ()
  );

  // Top sits one below the next free slot, wrapping at zero
  assign last_idx = new_idx - 1'b1;

  // Combinational read, a push is visible the next cycle
  assign ctrl.top_addr = ras_q[last_idx];

  // Detector must never request push and pop in one cycle
  push_pop_excl_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(ctrl.push && ctrl.pop)
  ) else $error("ras: push and pop asserted together");

endmodule : ras

`default_nettype wire

//--- rtl/call_ret_detect.sv
/*
 * Call and return detector for jal/jalr
 * Derives push/pop strobes, the return address, the return flag
 * and the jal target from the fetched instruction
 */
`timescale 1ns/100ps
`default_nettype none

module call_ret_detect (
  input  logic           instr_valid_i,
  input  logic           redirect_i,
  input  fe_pkg::inst_t  instr_i,
  input  fe_pkg::addr_t  pc_i,
  ras_ctrl_if.det        ctrl,
  output logic           is_jal_o,
  output logic           is_ret_o,
  output fe_pkg::addr_t  jal_target_o
);

  import fe_pkg::*;

  // Instruction fields
  logic [6:0] opcode;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  addr_t      j_imm;

  // Decoded flags
  logic is_jal_op;
  logic is_jalr_op;
  logic rd_link;
  logic rs1_link;
  logic is_call;
  logic is_ret;
  logic active;

  // ---------------------------------------------------------------------
  // Field extraction
  // ---------------------------------------------------------------------
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // J-type immediate, sign extended, bit 0 always zero
  assign j_imm = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ---------------------------------------------------------------------
  // Call and return classification
  // ---------------------------------------------------------------------
  assign is_jal_op  = (opcode == OPC_JAL);
  assign is_jalr_op = (opcode == OPC_JALR);
  assign rd_link    = (rd == LINK_X1) || (rd == LINK_X5);
  assign rs1_link   = (rs1 == LINK_X1) || (rs1 == LINK_X5);

  // Any jump that writes a link register is a call
  assign is_call = (is_jal_op || is_jalr_op) && rd_link;
  // Link rd means coroutine, handled as a call only
  assign is_ret  = is_jalr_op && rs1_link && !rd_link;

  // Nothing leaves the detector on idle or redirect cycles
  assign active = instr_valid_i && !redirect_i;

  // ---------------------------------------------------------------------
  // Outputs
  // ---------------------------------------------------------------------
  assign ctrl.push     = active && is_call;
  assign ctrl.pop      = active && is_ret;
  assign ctrl.ret_addr = active ? (pc_i + 32'd4) : '0;

  assign is_jal_o     = active && is_jal_op;
  assign is_ret_o     = active && is_ret;
  assign jal_target_o = active ? (pc_i + j_imm) : '0;

endmodule : call_ret_detect

`default_nettype wire

//--- rtl/next_pc_unit.sv
/*
 * Program counter register and next-PC selection
 * Priority is redirect, return, jal target, sequential, hold
 */
`timescale 1ns/100ps
`default_nettype none

module next_pc_unit #(
  parameter fe_pkg::addr_t BOOT_PC = 32'h0000_1000
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           instr_valid_i,
  input  logic           redirect_i,
  input  fe_pkg::addr_t  redirect_pc_i,
  input  logic           is_jal_i,
  input  logic           is_ret_i,
  input  fe_pkg::addr_t  jal_target_i,
  input  fe_pkg::addr_t  ras_top_i,
  output fe_pkg::addr_t  pc_o
);

  import fe_pkg::*;

  // Current and next program counter
  addr_t pc_q;
  addr_t pc_d;

  // ---------------------------------------------------------------------
  // Next PC selection
  // ---------------------------------------------------------------------
  // Return and jal flags arrive already qualified by valid
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (is_ret_i) begin
      // Predicted return target
      pc_d = ras_top_i;
    end else if (is_jal_i) begin
      pc_d = jal_target_i;
    end else if (instr_valid_i) begin
      // Also covers non-return jalr until a redirect arrives
      pc_d = pc_q + 32'd4;
    end
  end

  // ---------------------------------------------------------------------
  // PC register
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  // Alignment is lost only through a misaligned redirect
  pc_aligned_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((pc_q[1:0] == 2'b00) && !(redirect_i && (redirect_pc_i[1:0] != 2'b00)))
      |=> (pc_q[1:0] == 2'b00)
  ) else $error("next_pc_unit: PC lost word alignment");

endmodule : next_pc_unit

`default_nettype wire

//--- rtl/fetch_predictor_top.sv
/*
 * Next-PC stage of the fetch front end
 * Call/return detector, return address stack and PC unit
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_predictor_top #(
  parameter int unsigned   RAS_DEPTH = 4,
  parameter fe_pkg::addr_t BOOT_PC   = 32'h0000_1000
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           instr_valid_i,
  input  logic           redirect_i,
  input  fe_pkg::inst_t  instr_i,
  input  fe_pkg::addr_t  redirect_pc_i,
  output fe_pkg::addr_t  pc_o
);

  import fe_pkg::*;

  // Detector to PC unit
  logic  is_jal;
  logic  is_ret;
  addr_t jal_target;

  // Stack push/pop and address bundle
  ras_ctrl_if ras_ctrl ();

  // Decode the instruction at the current PC
  call_ret_detect call_ret_detect_inst (
    .instr_valid_i (instr_valid_i),
    .redirect_i    (redirect_i),
    .instr_i       (instr_i),
    .pc_i          (pc_o),
    .ctrl          (ras_ctrl),
    .is_jal_o      (is_jal),
    .is_ret_o      (is_ret),
    .jal_target_o  (jal_target)
  );

  ras #(
    .RAS_DEPTH (RAS_DEPTH)
  ) ras_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ctrl   (ras_ctrl)
  );

  // Top of stack feeds the return path of the PC mux
  next_pc_unit #(
    .BOOT_PC (BOOT_PC)
  ) next_pc_unit_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .is_jal_i      (is_jal),
    .is_ret_i      (is_ret),
    .jal_target_i  (jal_target),
    .ras_top_i     (ras_ctrl.top_addr),
    .pc_o          (pc_o)
  );

endmodule : fetch_predictor_top

`default_nettype wire

//--- verif/tb_fetch_predictor.sv
/*
 * Self-checking testbench for the fetch next-PC stage
 * Reference model of PC and return stack, checked by assertions
 * Sequential fetch, jal, nested calls, overflow, redirect, coroutine
 */
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_predictor;

  import fe_pkg::*;

  localparam int unsigned RAS_DEPTH = 4;
  localparam addr_t       BOOT_PC   = 32'h0000_1000;
  localparam int unsigned TIMEOUT   = 20;
  localparam inst_t       NOP       = 32'h0000_0013;
  // jalr x0, 0(x1)
  localparam inst_t       RET       = 32'h0000_8067;

  logic  clk_i;
  logic  rst_ni;
  logic  instr_valid_i;
  logic  redirect_i;
  inst_t instr_i;
  addr_t redirect_pc_i;
  addr_t pc_o;

  // Reference model state
  addr_t      exp_pc;
  addr_t      exp_stk [RAS_DEPTH];
  logic [1:0] exp_idx;
  string      test_name;

  fetch_predictor_top #(
    .RAS_DEPTH (RAS_DEPTH),
    .BOOT_PC   (BOOT_PC)
  ) fetch_predictor_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .redirect_i    (redirect_i),
    .instr_i       (instr_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc_o)
  );

  always #4 clk_i = ~clk_i;

  // ---------------------------------------------------------------------
  // Reference model, follows the call/return rules per instruction
  // ---------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    logic [6:0] opc;
    logic       lnk_rd;
    logic       lnk_rs1;
    addr_t      off;
    opc     = instr_i[6:0];
    lnk_rd  = (instr_i[11:7] == LINK_X1) || (instr_i[11:7] == LINK_X5);
    lnk_rs1 = (instr_i[19:15] == LINK_X1) || (instr_i[19:15] == LINK_X5);
    off     = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    if (!rst_ni) begin
      exp_pc  <= BOOT_PC;
      exp_idx <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        exp_stk[i] <= '0;
      end
    end else if (redirect_i) begin
      exp_pc <= redirect_pc_i;
    end else if (instr_valid_i) begin
      if (opc == OPC_JALR && lnk_rs1 && !lnk_rd) begin
        // Return takes the newest entry
        exp_pc  <= exp_stk[exp_idx - 2'd1];
        exp_idx <= exp_idx - 2'd1;
      end else begin
        if ((opc == OPC_JAL || opc == OPC_JALR) && lnk_rd) begin
          exp_stk[exp_idx] <= exp_pc + 32'd4;
          exp_idx          <= exp_idx + 2'd1;
        end
        exp_pc <= (opc == OPC_JAL) ? exp_pc + off : exp_pc + 32'd4;
      end
    end
  end

  // PC must track the model every cycle out of reset
  pc_match_a : assert property (@(posedge clk_i) disable iff (!rst_ni) pc_o == exp_pc)
    else begin
      $display("[FAIL] %s: expected %h, actual %h", test_name, $sampled(exp_pc),
               $sampled(pc_o));
      stop_run();
    end

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pc(input addr_t expected, input addr_t actual);
    assert (actual == expected) else begin
      $display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
      stop_run();
    end
  endtask

  function automatic inst_t enc_jal(input reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic inst_t enc_jalr(input reg_idx_t rd, input reg_idx_t rs1);
    return {12'd0, rs1, 3'b000, rd, OPC_JALR};
  endfunction

  // One cycle of input, returns the PC the instruction is presented at
  task automatic issue(input logic valid, input logic redir, input inst_t ins,
                       input addr_t rpc, output addr_t at_pc);
    @(posedge clk_i);
    instr_valid_i <= valid;
    redirect_i    <= redir;
    instr_i       <= ins;
    redirect_pc_i <= rpc;
    @(negedge clk_i);
    at_pc = exp_pc;
  endtask

  task automatic exec(input inst_t ins, output addr_t at_pc);
    issue(1'b1, 1'b0, ins, '0, at_pc);
  endtask

  task automatic idle_gap();
    int unsigned n;
    addr_t       unused;
    n = $urandom_range(2);
    repeat (n) issue(1'b0, 1'b0, NOP, '0, unused);
  endtask

  initial begin : stimulus
    int unsigned seed;
    int unsigned cnt;
    addr_t       p;
    addr_t       q;
    addr_t       nxt;
    addr_t       ret_q [$];
    logic [20:0] off;
    seed          = $urandom(32'h4a32);
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    redirect_i    = 1'b0;
    instr_i       = NOP;
    redirect_pc_i = '0;
    test_name     = "reset";
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    cnt = 0;
    while (rst_ni !== 1'b1 || pc_o !== BOOT_PC) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Timeout waiting for reset release and boot PC");
        stop_run();
      end
    end

    test_name = "sequential";
    exec(NOP, p);
    check_pc(BOOT_PC, p);
    repeat (4) begin
      exec(NOP, q);
      check_pc(p + 32'd4, q);
      p = q;
    end
    issue(1'b0, 1'b0, NOP, '0, q);
    issue(1'b0, 1'b0, NOP, '0, nxt);
    check_pc(q, nxt);

    // Plain jumps sit between a call and its return
    test_name = "jal";
    exec(enc_jal(LINK_X1, 21'h40), p);
    nxt = p + 32'd4;
    repeat (3) begin
      idle_gap();
      off = 21'($urandom) & 21'h1F_FFFC;
      exec(enc_jal(5'd0, off), p);
      exec(NOP, q);
      check_pc(p + {{11{off[20]}}, off}, q);
    end
    exec(RET, q);
    exec(NOP, q);
    check_pc(nxt, q);

    // Third call is followed at once by its return
    test_name = "nested";
    for (int i = 0; i < 3; i++) begin
      idle_gap();
      exec(enc_jal((i == 1) ? LINK_X5 : LINK_X1, 21'h40), p);
      ret_q.push_back(p + 32'd4);
    end
    exec(RET, q);
    for (int i = 0; i < 3; i++) begin
      exec((i < 2) ? RET : NOP, q);
      check_pc(ret_q.pop_back(), q);
    end

    // Fifth call overwrites the oldest slot
    test_name = "overflow";
    ret_q.delete();
    for (int i = 0; i < 5; i++) begin
      exec(enc_jal(LINK_X1, 21'h100), p);
      ret_q.push_back(p + 32'd4);
    end
    exec(RET, q);
    for (int i = 0; i < 5; i++) begin
      exec((i < 4) ? RET : NOP, q);
      check_pc((i < 4) ? ret_q[4-i] : ret_q[4], q);
    end

    test_name = "redirect";
    exec(enc_jal(LINK_X1, 21'h80), p);
    nxt = p + 32'd4;
    issue(1'b1, 1'b1, enc_jal(LINK_X1, 21'h80), 32'h0000_2000, q);
    issue(1'b1, 1'b1, RET, 32'h0000_3000, q);
    check_pc(32'h0000_2000, q);
    exec(RET, q);
    check_pc(32'h0000_3000, q);
    exec(NOP, q);
    check_pc(nxt, q);

    // jalr x1, 0(x1) pushes and falls through
    test_name = "coroutine";
    exec(enc_jalr(LINK_X1, LINK_X1), p);
    exec(RET, q);
    check_pc(p + 32'd4, q);
    exec(NOP, q);
    check_pc(p + 32'd4, q);

    issue(1'b0, 1'b0, NOP, '0, q);
    $display("*** PASSED ***");
    $finish;
  end

endmodule : tb_fetch_predictor

`default_nettype wire

//--- build.f
rtl/fe_pkg.sv
rtl/ras_ctrl_if.sv
rtl/updown_counter.sv
rtl/ras.sv
rtl/call_ret_detect.sv
rtl/next_pc_unit.sv
rtl/fetch_predictor_top.sv
verif/tb_fetch_predictor.sv
